/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_JALR    = 3'b000;
	localparam logic [2:0] F3_LB      = 3'b000;
	localparam logic [2:0] F3_LH      = 3'b001;
	localparam logic [2:0] F3_LW      = 3'b010;
	localparam logic [2:0] F3_LBU     = 3'b100;
	localparam logic [2:0] F3_LHU     = 3'b101;
	localparam logic [2:0] F3_SB      = 3'b000;
	localparam logic [2:0] F3_SH      = 3'b001;
	localparam logic [2:0] F3_SW      = 3'b010;
	localparam logic [2:0] F3_ADD_SUB = 3'b000; // add/sub, addi
	localparam logic [2:0] F3_SLL     = 3'b001; // sll, slli
	localparam logic [2:0] F3_SRL_SRA = 3'b101; // srl/sra, srli/srai
	localparam logic [2:0] F3_PRIV    = 3'b000; // ecall, ebreak, mret
	localparam logic [2:0] F3_CSRRW   = 3'b001;
	localparam logic [2:0] F3_CSRRS   = 3'b010;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

	// system words differ only in imm12
	localparam logic [11:0] IMM_ECALL  = 12'h000;
	localparam logic [11:0] IMM_EBREAK = 12'h001;
	localparam logic [11:0] IMM_MRET   = 12'h302;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_i_t;

	// one fetched word, seen as funct fields or as an immediate
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;

	typedef struct packed {
		logic        branch_taken;
		logic [31:0] branch_target;
		logic        jmp;
		logic [31:0] jmp_target;
		logic        csr_jmp;      // trap entry or mret
		logic [31:0] csr_target;
	} redirect_t;

	typedef struct packed {
		logic        en;
		logic [31:0] addr; // byte address
		logic [31:0] data;
	} imem_wr_t;

	typedef enum logic [1:0] {
		FETCH_IDLE        = 2'd0,
		FETCH_WAIT_MEM    = 2'd1,
		FETCH_WAIT_FINISH = 2'd2
	} fetch_state_e;

endpackage

`default_nettype wire

/* fetch/fetch_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    finish_i,
	output fetch_pkg::fetch_state_e state_o,
	output logic                    rd_en_o,
	output logic                    pc_adv_o,
	output logic                    inst_valid_o
);

	fetch_pkg::fetch_state_e state_q;
	fetch_pkg::fetch_state_e state_d;

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= fetch_pkg::FETCH_IDLE;
		else
			state_q <= state_d;
	end

	// issue, wait for the word, then hold until execute is done
	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::FETCH_IDLE: begin
				state_d = fetch_pkg::FETCH_WAIT_MEM;
			end
			fetch_pkg::FETCH_WAIT_MEM: begin
				state_d = fetch_pkg::FETCH_WAIT_FINISH;
			end
			fetch_pkg::FETCH_WAIT_FINISH: begin
				if (finish_i)
					state_d = fetch_pkg::FETCH_IDLE;
			end
			default: begin
				state_d = fetch_pkg::FETCH_IDLE;
			end
		endcase
	end

	// no read while the program is being loaded
	assign rd_en_o = (state_q == fetch_pkg::FETCH_IDLE) && !rst;

	// finish outside the wait phase has no effect
	assign pc_adv_o = (state_q == fetch_pkg::FETCH_WAIT_FINISH) && finish_i;

	assign inst_valid_o = (state_q == fetch_pkg::FETCH_WAIT_FINISH);
	assign state_o      = state_q;

	// a read in flight would change the word under a valid instruction
	a_rd_not_valid: assert property (@(posedge clk) disable iff (rst)
		!(rd_en_o && inst_valid_o))
		else $error("fetch_ctrl: read strobe during valid window");

	// advance closes the window, so the next cycle must start a fetch
	a_adv_in_finish: assert property (@(posedge clk) disable iff (rst)
		pc_adv_o |-> state_q == fetch_pkg::FETCH_WAIT_FINISH
			##1 state_q == fetch_pkg::FETCH_IDLE)
		else $error("fetch_ctrl: pc advance outside wait-finish");

endmodule

`default_nettype wire

/* fetch/pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_gen (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 adv_i,
	input  fetch_pkg::redirect_t redir_i,
	output logic [31:0]          pc_o
);

	logic [31:0] pc_q;
	logic [31:0] pc_plus4;
	logic [31:0] pc_next;

	assign pc_plus4 = pc_q + 32'd4;

	// trap/return wins over jump, jump over taken branch
	always_comb begin
		if (redir_i.csr_jmp)
			pc_next = redir_i.csr_target;
		else if (redir_i.jmp)
			pc_next = redir_i.jmp_target;
		else if (redir_i.branch_taken)
			pc_next = redir_i.branch_target;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc_q <= fetch_pkg::RESET_PC;
		else if (adv_i)
			pc_q <= pc_next;
	end

	assign pc_o = pc_q;

	// targets come in aligned, nothing here rounds them
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		pc_o[1:0] == 2'b00)
		else $error("pc_gen: pc not word aligned");

endmodule

`default_nettype wire

/* fetch/inst_sram.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_sram #(
	parameter int IMEM_DEPTH_LOG2 = 8
) (
	input  logic                clk,
	input  fetch_pkg::imem_wr_t wr_i,
	input  logic                rd_en_i,
	input  logic [31:0]         addr_i,
	output fetch_pkg::inst_u    inst_o
);

	localparam int DEPTH = 1 << IMEM_DEPTH_LOG2;

	logic [31:0] mem [DEPTH];

	logic [IMEM_DEPTH_LOG2-1:0] wr_idx;
	logic [IMEM_DEPTH_LOG2-1:0] rd_idx;

	// word index, upper address bits wrap
	assign wr_idx = wr_i.addr[IMEM_DEPTH_LOG2+1:2];
	assign rd_idx = addr_i[IMEM_DEPTH_LOG2+1:2];

	always_ff @(posedge clk) begin
		if (wr_i.en)
			mem[wr_idx] <= wr_i.data;
	end

	// output only moves on a strobe, held through the wait phases
	always_ff @(posedge clk) begin
		if (rd_en_i)
			inst_o <= mem[rd_idx];
	end

	// loading and fetching are kept apart by the controller
	a_no_rw_collide: assert property (@(posedge clk)
		(wr_i.en && rd_en_i) |-> (wr_idx != rd_idx))
		else $error("inst_sram: write and read hit index %0d together", rd_idx);

endmodule

`default_nettype wire

/* hdl/inst_legal_check.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_legal_check (
	input  fetch_pkg::inst_u inst_i,
	output logic             illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       csr_op;
	logic       sys_word;
	logic       legal;

	assign opcode = inst_i.r.opcode;
	assign funct3 = inst_i.r.funct3;
	assign funct7 = inst_i.r.funct7;

	assign csr_op = (funct3 == fetch_pkg::F3_CSRRW) || (funct3 == fetch_pkg::F3_CSRRS);

	// ecall/ebreak/mret need zero rs1, rd and funct3
	assign sys_word = (funct3 == fetch_pkg::F3_PRIV)
		&& (inst_i.i.rs1 == 5'd0) && (inst_i.i.rd == 5'd0)
		&& ((inst_i.i.imm12 == fetch_pkg::IMM_ECALL)
			|| (inst_i.i.imm12 == fetch_pkg::IMM_EBREAK)
			|| (inst_i.i.imm12 == fetch_pkg::IMM_MRET));

	always_comb begin
		legal = 1'b0;
		case (opcode)
			fetch_pkg::OPC_LUI,
			fetch_pkg::OPC_AUIPC,
			fetch_pkg::OPC_JAL,
			fetch_pkg::OPC_BRANCH: begin
				legal = 1'b1;
			end
			fetch_pkg::OPC_JALR: begin
				legal = (funct3 == fetch_pkg::F3_JALR);
			end
			fetch_pkg::OPC_LOAD: begin
				legal = (funct3 == fetch_pkg::F3_LB) || (funct3 == fetch_pkg::F3_LH)
					|| (funct3 == fetch_pkg::F3_LW) || (funct3 == fetch_pkg::F3_LBU)
					|| (funct3 == fetch_pkg::F3_LHU);
			end
			fetch_pkg::OPC_STORE: begin
				legal = (funct3 == fetch_pkg::F3_SB) || (funct3 == fetch_pkg::F3_SH)
					|| (funct3 == fetch_pkg::F3_SW);
			end
			fetch_pkg::OPC_OP_IMM: begin
				if (funct3 == fetch_pkg::F3_SLL)
					legal = (funct7 == fetch_pkg::F7_BASE);
				else if (funct3 == fetch_pkg::F3_SRL_SRA)
					legal = (funct7 == fetch_pkg::F7_BASE) || (funct7 == fetch_pkg::F7_ALT);
				else
					legal = 1'b1; // imm is free for the rest
			end
			fetch_pkg::OPC_OP: begin
				if (funct7 == fetch_pkg::F7_BASE)
					legal = 1'b1;
				else if (funct7 == fetch_pkg::F7_ALT) // sub and sra only
					legal = (funct3 == fetch_pkg::F3_ADD_SUB)
						|| (funct3 == fetch_pkg::F3_SRL_SRA);
			end
			fetch_pkg::OPC_SYSTEM: begin
				legal = csr_op || sys_word;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign illegal_o = !legal;

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
	parameter int IMEM_DEPTH_LOG2 = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 finish_i,
	input  fetch_pkg::redirect_t redir_i,
	input  fetch_pkg::imem_wr_t  imem_wr_i,
	output logic [31:0]          pc_o,
	output fetch_pkg::inst_u     inst_o,
	output logic                 inst_valid_o,
	output logic                 illegal_o
);

	logic             rd_en;
	logic             pc_adv;
	logic [31:0]      pc;
	fetch_pkg::inst_u inst;

	fetch_ctrl fetch_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.finish_i     (finish_i),
		.state_o      (),             // debug only
		.rd_en_o      (rd_en),
		.pc_adv_o     (pc_adv),
		.inst_valid_o (inst_valid_o)
	);

	pc_gen pc_gen_i (
		.clk     (clk),
		.rst     (rst),
		.adv_i   (pc_adv),
		.redir_i (redir_i),
		.pc_o    (pc)
	);

	inst_sram #(
		.IMEM_DEPTH_LOG2 (IMEM_DEPTH_LOG2)
	) inst_sram_i (
		.clk     (clk),
		.wr_i    (imem_wr_i),
		.rd_en_i (rd_en),
		.addr_i  (pc),
		.inst_o  (inst)
	);

	// flag only means something inside the valid window
	inst_legal_check inst_legal_check_i (
		.inst_i    (inst),
		.illegal_o (illegal_o)
	);

	assign pc_o   = pc;
	assign inst_o = inst;

endmodule

`default_nettype wire

/* bench/fetch_ref_model.svh */
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

// copy of what was written into the instruction memory
logic [31:0] image_mem [IMEM_WORDS];

function automatic int image_index(input logic [31:0] addr);
	return int'(addr[IMEM_DEPTH_LOG2+1:2]); // upper bits wrap
endfunction

// supported subset, one table row per opcode
function automatic logic is_legal_word(input logic [31:0] w);
	logic [6:0] opc;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [7:0] f3_ok;
	opc = w[6:0];
	f3 = w[14:12];
	f7 = w[31:25];
	case (opc)
		7'b0110111, 7'b0010111, 7'b1101111, 7'b1100011: return 1'b1;
		7'b1100111: return f3 == 3'b000;
		7'b0000011: begin
			f3_ok = 8'b0011_0111; // lb lh lw lbu lhu
			return f3_ok[f3];
		end
		7'b0100011: begin
			f3_ok = 8'b0000_0111; // sb sh sw
			return f3_ok[f3];
		end
		7'b0010011: begin
			if (f3 == 3'b001)
				return f7 == 7'h00;
			if (f3 == 3'b101)
				return f7 == 7'h00 || f7 == 7'h20;
			return 1'b1;
		end
		7'b0110011: begin
			if (f7 == 7'h00)
				return 1'b1;
			return f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101);
		end
		7'b1110011: begin
			if (f3 == 3'b001 || f3 == 3'b010)
				return 1'b1;
			// exact ecall, ebreak and mret words only
			return w[19:7] == 13'd0
				&& (w[31:20] == 12'h000 || w[31:20] == 12'h001 || w[31:20] == 12'h302);
		end
		default: return 1'b0;
	endcase
endfunction

function automatic logic [31:0] predict_pc(input logic [31:0] cur,
	input fetch_pkg::redirect_t r);
	if (r.csr_jmp)
		return r.csr_target;
	if (r.jmp)
		return r.jmp_target;
	if (r.branch_taken)
		return r.branch_target;
	return cur + 32'd4;
endfunction

// sub picks the funct7 or system immediate variant
function automatic logic [31:0] pick_word(input int kind, input int sub);
	logic [31:0] r;
	logic [6:0] f7;
	logic [11:0] priv;
	logic [2:0] sh_f3;
	r = $random(seed);
	case (sub % 4)
		0: f7 = 7'b0000000;
		1: f7 = 7'b0100000;
		default: f7 = r[31:25];
	endcase
	case (sub % 4)
		0: priv = fetch_pkg::IMM_ECALL;
		1: priv = fetch_pkg::IMM_EBREAK;
		2: priv = fetch_pkg::IMM_MRET;
		default: priv = r[31:20]; // mostly a hole
	endcase
	case (r[1:0])
		2'd0: sh_f3 = 3'b001;
		2'd1: sh_f3 = 3'b101;
		default: sh_f3 = r[14:12];
	endcase
	case (kind)
		0: return {r[31:7], fetch_pkg::OPC_LUI};
		1: return {r[31:7], fetch_pkg::OPC_AUIPC};
		2: return {r[31:7], fetch_pkg::OPC_JAL};
		3: return {r[31:15], 3'b000, r[11:7], fetch_pkg::OPC_JALR};
		4: return {r[31:7], fetch_pkg::OPC_BRANCH};
		5: return {r[31:7], fetch_pkg::OPC_LOAD}; // funct3 may hit a hole
		6: return {r[31:7], fetch_pkg::OPC_STORE};
		7: return {f7, r[24:15], sh_f3, r[11:7], fetch_pkg::OPC_OP_IMM};
		8: return {f7, r[24:7], fetch_pkg::OPC_OP};
		9: return {priv, 13'd0, fetch_pkg::OPC_SYSTEM};
		10: return {r[31:15], 1'b0, r[13:12], r[11:7], fetch_pkg::OPC_SYSTEM};
		default: return r;
	endcase
endfunction

`endif

/* bench/tb_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

	localparam int IMEM_DEPTH_LOG2 = 8;
	localparam int IMEM_WORDS = 1 << IMEM_DEPTH_LOG2;
	localparam int MAX_DELAY = 10;
	localparam int N_SEQ = 48;
	localparam int N_REDIR = 40;
	localparam int N_BP = 30;
	localparam int N_INSTR = N_SEQ + N_REDIR + N_BP;
	// load and reset, then every fetch at its longest
	localparam int WATCHDOG_NS = (IMEM_WORDS + 8) * 4
		+ N_INSTR * (3 + MAX_DELAY + 2) * 4 + 400;

	logic clk = 1'b0;
	logic rst;
	logic finish;
	fetch_pkg::redirect_t redir;
	fetch_pkg::imem_wr_t imem_wr;
	logic [31:0] pc;
	fetch_pkg::inst_u inst;
	logic inst_valid;
	logic illegal;

	integer seed = 32'hc3b0;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int test_checks = 0;
	int legal_errors = 0;
	int legal_checks = 0;
	logic [31:0] exp_pc;

	`include "fetch_ref_model.svh"

	always #2 clk = ~clk;

	fetch_top #(
		.IMEM_DEPTH_LOG2 (IMEM_DEPTH_LOG2)
	) fetch_top_i (
		.clk          (clk),
		.rst          (rst),
		.finish_i     (finish),
		.redir_i      (redir),
		.imem_wr_i    (imem_wr),
		.pc_o         (pc),
		.inst_o       (inst),
		.inst_valid_o (inst_valid),
		.illegal_o    (illegal)
	);

	task automatic step();
		@(posedge clk);
		#1; // outputs settled, inputs change here
	endtask

	task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_inst(input string name, input fetch_pkg::inst_u got,
		input fetch_pkg::inst_u exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_illegal(input logic got, input logic exp);
		legal_checks++;
		if (got !== exp) begin
			legal_errors++;
			$display("error at %0t ns: illegal_o got %b expected %b", $time, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		errors += test_errors;
		checks += test_checks;
		test_errors = 0;
		test_checks = 0;
	endtask

	function automatic fetch_pkg::redirect_t random_redirect();
		fetch_pkg::redirect_t r;
		logic [31:0] flags;
		flags = $random(seed);
		r.branch_taken = flags[0];
		r.jmp = flags[1];
		r.csr_jmp = flags[2];
		r.branch_target = {$random(seed)} & 32'hffff_fffc;
		r.jmp_target = {$random(seed)} & 32'hffff_fffc;
		r.csr_target = {$random(seed)} & 32'hffff_fffc;
		return r;
	endfunction

	task automatic load_image();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			if (i < 48)
				image_mem[i] = pick_word(i % 12, i / 12); // every class and variant once
			else
				image_mem[i] = pick_word($unsigned($random(seed)) % 12, i % 4);
			imem_wr.en = 1'b1;
			imem_wr.addr = 32'(i) << 2;
			imem_wr.data = image_mem[i];
			step();
		end
		imem_wr = '0;
	endtask

	task automatic wait_valid(output logic seen);
		int n;
		n = 0;
		while (!inst_valid && n < 8) begin
			step();
			n++;
		end
		seen = inst_valid;
		if (!seen) begin
			test_errors++;
			$display("error at %0t ns: no valid window within 8 cycles", $time);
		end
	endtask

	// one instruction from its valid window to the next fetch
	task automatic run_instr(input int max_delay, input logic use_redir, input logic stray);
		logic seen;
		int delay;
		fetch_pkg::inst_u exp_inst;
		fetch_pkg::redirect_t r;
		wait_valid(seen);
		if (!seen)
			return;
		exp_inst = image_mem[image_index(exp_pc)];
		check_pc("pc_o", pc, exp_pc);
		check_inst("inst_o", inst, exp_inst);
		check_illegal(illegal, !is_legal_word(exp_inst));
		delay = $unsigned($random(seed)) % (max_delay + 1);
		repeat (delay) begin
			step();
			check_flag("inst_valid_o", inst_valid, 1'b1);
			check_pc("pc_o", pc, exp_pc);
			check_inst("inst_o", inst, exp_inst);
		end
		r = use_redir ? random_redirect() : '0;
		finish = 1'b1;
		redir = r;
		exp_pc = predict_pc(exp_pc, r);
		step();
		finish = 1'b0;
		redir = '0;
		check_flag("inst_valid_o", inst_valid, 1'b0);
		check_pc("pc_o", pc, exp_pc);
		if (stray) begin
			finish = 1'b1; // controller is idle, must be ignored
			redir = random_redirect();
			step();
			finish = 1'b0;
			redir = '0;
			check_flag("inst_valid_o", inst_valid, 1'b0);
			check_pc("pc_o", pc, exp_pc);
		end
	endtask

	initial begin
		rst = 1'b1;
		finish = 1'b0;
		redir = '0;
		imem_wr = '0;
		exp_pc = fetch_pkg::RESET_PC;
		load_image();
		repeat (3) step();
		rst = 1'b0;
		check_pc("pc_o", pc, fetch_pkg::RESET_PC);
		check_flag("inst_valid_o", inst_valid, 1'b0);
		step();
		check_flag("inst_valid_o", inst_valid, 1'b0);
		step();
		check_flag("inst_valid_o", inst_valid, 1'b1);
		check_pc("pc_o", pc, fetch_pkg::RESET_PC);
		finish_test("reset");
		for (int i = 0; i < N_SEQ; i++)
			run_instr(0, 1'b0, 1'b0);
		finish_test("sequential");
		for (int i = 0; i < N_REDIR; i++)
			run_instr(2, 1'b1, 1'b0);
		finish_test("redirect");
		for (int i = 0; i < N_BP; i++)
			run_instr(MAX_DELAY, i[0], 1'b1);
		finish_test("backpressure");
		$display("test legality: %0d checks, %0d errors", legal_checks, legal_errors);
		errors += legal_errors;
		checks += legal_checks;
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the fetch loop stopped making progress",
			WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
common/fetch_pkg.sv
fetch/fetch_ctrl.sv
fetch/pc_gen.sv
fetch/inst_sram.sv
hdl/inst_legal_check.sv
hdl/fetch_top.sv
bench/tb_fetch.sv
